// ==== files.f ====
+incdir+verif
hdl/fpsimd_pkg.sv
hdl/fpsimd_issue.sv
hdl/fpsimd_queue.sv
hdl/fpsimd_exec.sv
hdl/fpsimd_unit.sv
verif/tb_fpsimd.sv

// ==== Makefile ====
.PHONY: all run clean

all: run

obj_dir/Vtb_fpsimd: files.f hdl/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert -Wno-fatal --top-module tb_fpsimd -f files.f

run: obj_dir/Vtb_fpsimd
	./obj_dir/Vtb_fpsimd

clean:
	rm -rf obj_dir

// ==== verif/tb_fpsimd_model.svh ====
`ifndef TB_FPSIMD_MODEL_SVH
`define TB_FPSIMD_MODEL_SVH

// galois form, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  if (s[0]) begin
    return (s >> 1) ^ 32'h8020_0003;
  end
  return s >> 1;
endfunction

function automatic logic lane_is_nan(input logic [31:0] f);
  return (f[30:23] == 8'hff) && (f[22:0] != '0);
endfunction

// unsigned key with the same order as the float, both zeros on one key
function automatic logic [31:0] order_key(input logic [31:0] f);
  if (f[30:0] == '0) begin
    return 32'h8000_0000;
  end else if (f[31]) begin
    return {1'b0, ~f[30:0]};
  end
  return {1'b1, f[30:0]};
endfunction

// result packed as {perr, illegal, invalid, mask, data}
function automatic logic [68:0] expect_result(input logic [3:0] op, input logic [64:0] a,
                                              input logic [64:0] b);
  logic [63:0] data;
  logic [1:0]  mask;
  logic        any_nan;
  logic        nan;
  logic [31:0] ka;
  logic [31:0] kb;
  data = '0;
  mask = '0;
  any_nan = 1'b0;
  if ((^a) || (^b)) begin
    return {3'b100, 2'b00, 64'd0};
  end
  case (op)
    op_and:   data = a[63:0] & b[63:0];
    op_or:    data = a[63:0] | b[63:0];
    op_xor:   data = a[63:0] ^ b[63:0];
    op_andn:  data = a[63:0] & ~b[63:0];
    op_swap:  data = {b[31:0], b[63:32]};
    op_dup:   data = {b[31:0], b[31:0]};
    op_copya: data = a[63:0];
    op_cmpeq, op_cmplt, op_cmple: begin
      for (int i = 0; i < 2; i++) begin
        ka = order_key(a[i*32 +: 32]);
        kb = order_key(b[i*32 +: 32]);
        nan = lane_is_nan(a[i*32 +: 32]) || lane_is_nan(b[i*32 +: 32]);
        any_nan = any_nan | nan;
        case (op)
          op_cmpeq: mask[i] = !nan && (ka == kb);
          op_cmplt: mask[i] = !nan && (ka < kb);
          default:  mask[i] = !nan && (ka <= kb);
        endcase
        data[i*32 +: 32] = {32{mask[i]}};
      end
    end
    default: return {3'b010, 2'b00, 64'd0};
  endcase
  return {2'b00, ((op == op_cmplt) || (op == op_cmple)) && any_nan, mask, data};
endfunction

`endif

// ==== verif/tb_fpsimd.sv ====
`timescale 1ns/1ps

module tb_fpsimd;

  import fpsimd_pkg::*;

  `include "tb_fpsimd_model.svh"

  localparam int num_tests    = 400;
  localparam int burst_tests  = 16;
  localparam int reset_cycles = 5;

  logic        clk;
  logic        rst;
  logic        in_valid;
  logic        in_ready;
  logic [3:0]  in_op;
  logic [64:0] in_a;
  logic [64:0] in_b;
  logic        res_ready;
  logic        res_valid;
  logic [63:0] res_data;
  logic [1:0]  res_mask;
  logic        res_invalid;
  logic        res_perr;
  logic        res_illegal;

  logic [31:0] lfsr_state = 32'd72;
  int          cycle = 0;
  int          received = 0;
  int          stall_left = 0;
  logic [68:0] exp_q [$];
  int          acc_q [$];
  logic [3:0]  op_q [$];

  fpsimd_unit #(
    .queue_depth (4)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_op       (in_op),
    .in_a        (in_a),
    .in_b        (in_b),
    .res_ready   (res_ready),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_mask    (res_mask),
    .res_invalid (res_invalid),
    .res_perr    (res_perr),
    .res_illegal (res_illegal)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check(input string name, input logic [63:0] expv, input logic [63:0] actv);
    if (actv !== expv) begin
      $display("mismatch %s expected %h actual %h", name, expv, actv);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // zeros, nans, infinities and plus or minus one
  function automatic logic [31:0] special_lane(input logic [2:0] k);
    case (k)
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7fc0_0000;
      3'd3:    return 32'hff80_0001;
      3'd4:    return 32'h7f80_0000;
      3'd5:    return 32'hff80_0000;
      3'd6:    return 32'h3f80_0000;
      default: return 32'hbf80_0000;
    endcase
  endfunction

  function automatic logic [31:0] pick_lane();
    if (take_bits(1) == 0) begin
      return special_lane(3'(take_bits(3)));
    end
    return take_bits(32);
  endfunction

  task automatic load_op();
    logic [31:0] r;
    logic [63:0] a;
    logic [63:0] b;
    if (take_bits(3) == 0) begin
      in_op = (take_bits(2) == 0) ? 4'd7 : 4'(11 + take_bits(3) % 5);
    end else begin
      r = take_bits(4) % 10;
      in_op = (r > 6) ? 4'(r + 1) : 4'(r);
    end
    for (int i = 0; i < 2; i++) begin
      a[i*32 +: 32] = pick_lane();
      // equal pairs now and then
      b[i*32 +: 32] = (take_bits(2) == 0) ? a[i*32 +: 32] : pick_lane();
    end
    in_a = {^a, a};
    in_b = {^b, b};
    if (take_bits(4) == 0) begin
      in_a[64] = ~in_a[64];
    end
    if (take_bits(4) == 0) begin
      in_b[64] = ~in_b[64];
    end
  endtask

  task automatic update_ready();
    if (stall_left > 0) begin
      stall_left--;
      res_ready = 1'b0;
    end else if (take_bits(3) == 0) begin
      stall_left = int'(take_bits(3));
      res_ready = 1'b0;
    end else begin
      res_ready = 1'b1;
    end
  endtask

  // stress adds input gaps and output stalls
  task automatic run_ops(input int count, input bit stress);
    int done;
    bit accepted;
    done = 0;
    @(posedge clk);
    #1;
    load_op();
    in_valid = 1'b1;
    while (done < count) begin
      @(negedge clk);
      if (!stress) begin
        check($sformatf("burst op %0d in_ready", done), 64'd1, 64'(in_ready));
      end
      accepted = in_valid && in_ready;
      if (accepted) begin
        exp_q.push_back(expect_result(in_op, in_a, in_b));
        acc_q.push_back(cycle);
        op_q.push_back(in_op);
      end
      @(posedge clk);
      #1;
      if (accepted) begin
        done++;
      end
      if (stress) begin
        update_ready();
      end
      if (accepted || !in_valid) begin
        if (done == count || (stress && take_bits(3) == 0)) begin
          in_valid = 1'b0;
        end else begin
          load_op();
          in_valid = 1'b1;
        end
      end
    end
  endtask

  initial begin : compare
    logic [68:0] expv;
    logic [68:0] held_val;
    bit          held;
    int          acc;
    logic [3:0]  op;
    string       tag;
    held = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (held) begin
          check($sformatf("test %0d held res_valid", received), 64'd1, 64'(res_valid));
          check($sformatf("test %0d held outputs", received), 64'(held_val[68:64]),
                64'({res_perr, res_illegal, res_invalid, res_mask}));
          check($sformatf("test %0d held data", received), held_val[63:0], res_data);
        end
        held = res_valid && !res_ready;
        held_val = {res_perr, res_illegal, res_invalid, res_mask, res_data};
        if (res_valid && res_ready && exp_q.size() == 0) begin
          $display("a result arrived with no operation pending");
          $display("TEST FAILED");
          $fatal(1, "unexpected result");
        end else if (res_valid && res_ready) begin
          expv = exp_q.pop_front();
          acc = acc_q.pop_front();
          op = op_q.pop_front();
          tag = $sformatf("test %0d op %0d", received, op);
          check({tag, " res_data"}, expv[63:0], res_data);
          check({tag, " res_mask"}, 64'(expv[65:64]), 64'(res_mask));
          check({tag, " perr/illegal/invalid"}, 64'(expv[68:66]),
                64'({res_perr, res_illegal, res_invalid}));
          // no back-pressure in the burst phase
          if (received < burst_tests) begin
            check({tag, " latency"}, 64'd3, 64'(cycle - acc));
          end
          received++;
        end
      end
    end
  end

  initial begin
    repeat (num_tests * 40 + reset_cycles) @(posedge clk);
    $display("run timed out before all results arrived");
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = '0;
    in_a = '0;
    in_b = '0;
    res_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check("reset res_valid", 64'd0, 64'(res_valid));
    check("reset in_ready", 64'd1, 64'(in_ready));
    run_ops(burst_tests, 1'b0);
    wait (received == burst_tests);
    run_ops(num_tests - burst_tests, 1'b1);
    res_ready = 1'b1;
    wait (received == num_tests);
    // a few idle cycles so a stray extra result still gets caught
    repeat (4) @(posedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== hdl/fpsimd_unit.sv ====
`timescale 1ns/1ps

module fpsimd_unit #(
  parameter int queue_depth = 4
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             in_valid,
  output logic                             in_ready,
  input  logic [fpsimd_pkg::op_w-1:0]      in_op,
  input  logic [fpsimd_pkg::data_w:0]      in_a,
  input  logic [fpsimd_pkg::data_w:0]      in_b,
  input  logic                             res_ready,
  output logic                             res_valid,
  output logic [fpsimd_pkg::data_w-1:0]    res_data,
  output logic [fpsimd_pkg::num_lanes-1:0] res_mask,
  output logic                             res_invalid,
  output logic                             res_perr,
  output logic                             res_illegal
);

  import fpsimd_pkg::*;

  logic            iss_valid;
  logic            iss_ready;
  logic [op_w-1:0] iss_op;
  simd_word_u      iss_a;
  simd_word_u      iss_b;
  logic            iss_perr;
  logic            iss_illegal;

  logic            q_valid;
  logic            q_ready;
  logic [op_w-1:0] q_op;
  simd_word_u      q_a;
  simd_word_u      q_b;
  logic            q_perr;
  logic            q_illegal;

  fpsimd_issue u_issue (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_op       (in_op),
    .in_a        (in_a),
    .in_b        (in_b),
    .iss_valid   (iss_valid),
    .iss_ready   (iss_ready),
    .iss_op      (iss_op),
    .iss_a       (iss_a),
    .iss_b       (iss_b),
    .iss_perr    (iss_perr),
    .iss_illegal (iss_illegal)
  );

  fpsimd_queue #(
    .queue_depth (queue_depth)
  ) u_queue (
    .clk         (clk),
    .rst         (rst),
    .iss_valid   (iss_valid),
    .iss_ready   (iss_ready),
    .iss_op      (iss_op),
    .iss_a       (iss_a),
    .iss_b       (iss_b),
    .iss_perr    (iss_perr),
    .iss_illegal (iss_illegal),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_op        (q_op),
    .q_a         (q_a),
    .q_b         (q_b),
    .q_perr      (q_perr),
    .q_illegal   (q_illegal)
  );

  fpsimd_exec u_exec (
    .clk         (clk),
    .rst         (rst),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_op        (q_op),
    .q_a         (q_a),
    .q_b         (q_b),
    .q_perr      (q_perr),
    .q_illegal   (q_illegal),
    .res_ready   (res_ready),
    .res_valid   (res_valid),
    .res_data    (res_data),
    .res_mask    (res_mask),
    .res_invalid (res_invalid),
    .res_perr    (res_perr),
    .res_illegal (res_illegal)
  );

endmodule

// ==== hdl/fpsimd_exec.sv ====
`timescale 1ns/1ps

module fpsimd_exec (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             q_valid,
  output logic                             q_ready,
  input  logic [fpsimd_pkg::op_w-1:0]      q_op,
  input  fpsimd_pkg::simd_word_u           q_a,
  input  fpsimd_pkg::simd_word_u           q_b,
  input  logic                             q_perr,
  input  logic                             q_illegal,
  input  logic                             res_ready,
  output logic                             res_valid,
  output logic [fpsimd_pkg::data_w-1:0]    res_data,
  output logic [fpsimd_pkg::num_lanes-1:0] res_mask,
  output logic                             res_invalid,
  output logic                             res_perr,
  output logic                             res_illegal
);

  import fpsimd_pkg::*;

  simd_word_u           calc;
  logic [num_lanes-1:0] cmp_mask;
  logic [num_lanes-1:0] lane_nan;
  logic [num_lanes-1:0] lane_eq;
  logic [num_lanes-1:0] lane_lt;
  logic                 is_cmp;
  logic                 is_ordered;
  logic                 q_fire;

  function automatic logic is_nan(input flane_t f);
    return (&f.exp) && (|f.frac);
  endfunction

  function automatic logic is_zero(input flane_t f);
    return {f.exp, f.frac} == '0;
  endfunction

  // sign-magnitude ordering, +0 and -0 tie
  function automatic logic lane_less(input flane_t a, input flane_t b);
    logic less;
    if (is_zero(a) && is_zero(b)) begin
      less = 1'b0;
    end else if (a.sign != b.sign) begin
      less = a.sign;
    end else if (a.sign) begin
      less = {a.exp, a.frac} > {b.exp, b.frac};
    end else begin
      less = {a.exp, a.frac} < {b.exp, b.frac};
    end
    return less;
  endfunction

  assign is_cmp     = (q_op == op_cmpeq) || is_ordered;
  assign is_ordered = (q_op == op_cmplt) || (q_op == op_cmple);

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_nan[i] = is_nan(q_a.lane[i]) || is_nan(q_b.lane[i]);
      lane_eq[i]  = (q_a.lane[i] == q_b.lane[i]) ||
                    (is_zero(q_a.lane[i]) && is_zero(q_b.lane[i]));
      lane_lt[i]  = lane_less(q_a.lane[i], q_b.lane[i]);
    end
  end

  always_comb begin
    calc.raw = '0;
    cmp_mask = '0;
    case (q_op)
      op_and:   calc.raw = q_a.raw & q_b.raw;
      op_or:    calc.raw = q_a.raw | q_b.raw;
      op_xor:   calc.raw = q_a.raw ^ q_b.raw;
      op_andn:  calc.raw = q_a.raw & ~q_b.raw;
      op_swap: begin
        calc.lane[0] = q_b.lane[1];
        calc.lane[1] = q_b.lane[0];
      end
      op_dup: begin
        calc.lane[0] = q_b.lane[0];
        calc.lane[1] = q_b.lane[0];
      end
      op_copya: calc.raw = q_a.raw;
      // nan lanes never compare true
      op_cmpeq: cmp_mask = lane_eq & ~lane_nan;
      op_cmplt: cmp_mask = lane_lt & ~lane_nan;
      op_cmple: cmp_mask = (lane_lt | lane_eq) & ~lane_nan;
      default:  calc.raw = '0;
    endcase
    if (is_cmp) begin
      for (int i = 0; i < num_lanes; i++) begin
        calc.raw[i*lane_w +: lane_w] = {lane_w{cmp_mask[i]}};
      end
    end
  end

  // output slot frees once the consumer takes it
  assign q_ready = !res_valid || res_ready;
  assign q_fire  = q_valid && q_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (q_fire) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (q_fire) begin
      if (q_perr || q_illegal) begin
        res_data    <= '0;
        res_mask    <= '0;
        res_invalid <= 1'b0;
      end else begin
        res_data    <= calc.raw;
        res_mask    <= cmp_mask;
        res_invalid <= is_ordered && (|lane_nan);
      end
      // parity error wins over a bad opcode
      res_perr    <= q_perr;
      res_illegal <= q_illegal && !q_perr;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    res_valid |-> !(res_perr && res_illegal));

  // stalled result holds until taken
  assert property (@(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid &&
      $stable({res_data, res_mask, res_invalid, res_perr, res_illegal}));

endmodule

// ==== hdl/fpsimd_queue.sv ====
`timescale 1ns/1ps

module fpsimd_queue #(
  parameter int queue_depth = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        iss_valid,
  output logic                        iss_ready,
  input  logic [fpsimd_pkg::op_w-1:0] iss_op,
  input  fpsimd_pkg::simd_word_u      iss_a,
  input  fpsimd_pkg::simd_word_u      iss_b,
  input  logic                        iss_perr,
  input  logic                        iss_illegal,
  output logic                        q_valid,
  input  logic                        q_ready,
  output logic [fpsimd_pkg::op_w-1:0] q_op,
  output fpsimd_pkg::simd_word_u      q_a,
  output fpsimd_pkg::simd_word_u      q_b,
  output logic                        q_perr,
  output logic                        q_illegal
);

  import fpsimd_pkg::*;

  localparam int ptr_w = $clog2(queue_depth);
  localparam logic [ptr_w:0] full_cnt = (ptr_w + 1)'(queue_depth);

  logic [op_w-1:0] mem_op [queue_depth];
  simd_word_u      mem_a [queue_depth];
  simd_word_u      mem_b [queue_depth];
  logic            mem_perr [queue_depth];
  logic            mem_illegal [queue_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             wr_en;
  logic             rd_en;

  assign iss_ready = count != full_cnt;
  assign q_valid   = count != '0;
  assign wr_en     = iss_valid && iss_ready;
  assign rd_en     = q_valid && q_ready;

  // head entry read straight out of storage
  assign q_op      = mem_op[rd_ptr];
  assign q_a       = mem_a[rd_ptr];
  assign q_b       = mem_b[rd_ptr];
  assign q_perr    = mem_perr[rd_ptr];
  assign q_illegal = mem_illegal[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_op[wr_ptr]      <= iss_op;
      mem_a[wr_ptr]       <= iss_a;
      mem_b[wr_ptr]       <= iss_b;
      mem_perr[wr_ptr]    <= iss_perr;
      mem_illegal[wr_ptr] <= iss_illegal;
    end
  end

  // no write into a full queue, count never passes the depth
  assert property (@(posedge clk) disable iff (rst)
    count <= full_cnt);

  // no read from an empty one, pointers stay in step with the count
  assert property (@(posedge clk) disable iff (rst)
    wr_ptr == ptr_w'(rd_ptr + count));

endmodule

// ==== hdl/fpsimd_issue.sv ====
`timescale 1ns/1ps

module fpsimd_issue (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_valid,
  output logic                        in_ready,
  input  logic [fpsimd_pkg::op_w-1:0] in_op,
  input  logic [fpsimd_pkg::data_w:0] in_a,
  input  logic [fpsimd_pkg::data_w:0] in_b,
  output logic                        iss_valid,
  input  logic                        iss_ready,
  output logic [fpsimd_pkg::op_w-1:0] iss_op,
  output fpsimd_pkg::simd_word_u      iss_a,
  output fpsimd_pkg::simd_word_u      iss_b,
  output logic                        iss_perr,
  output logic                        iss_illegal
);

  import fpsimd_pkg::*;

  logic in_fire;
  logic in_perr;
  logic in_illegal;

  // slot frees when the held op moves on
  assign in_ready = !iss_valid || iss_ready;
  assign in_fire  = in_valid && in_ready;

  // even parity over all 65 bits
  assign in_perr = (^in_a) || (^in_b);

  always_comb begin
    case (in_op)
      op_and, op_or, op_xor, op_andn,
      op_swap, op_dup, op_copya,
      op_cmpeq, op_cmplt, op_cmple: in_illegal = 1'b0;
      default:                      in_illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else if (in_fire) begin
      iss_valid <= 1'b1;
    end else if (iss_ready) begin
      iss_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      iss_op      <= in_op;
      iss_a.raw   <= in_a[data_w-1:0];
      iss_b.raw   <= in_b[data_w-1:0];
      iss_perr    <= in_perr;
      iss_illegal <= in_illegal;
    end
  end

  // held op stays put until the queue takes it
  assert property (@(posedge clk) disable iff (rst)
    iss_valid && !iss_ready |=>
      iss_valid && $stable({iss_op, iss_a, iss_b, iss_perr, iss_illegal}));

endmodule

// ==== hdl/fpsimd_pkg.sv ====
package fpsimd_pkg;

  localparam int data_w    = 64;
  localparam int lane_w    = 32;
  localparam int num_lanes = 2;
  localparam int op_w      = 4;

  // bitwise ops on the raw word
  localparam logic [op_w-1:0] op_and   = 4'd0;
  localparam logic [op_w-1:0] op_or    = 4'd1;
  localparam logic [op_w-1:0] op_xor   = 4'd2;
  // a and not b
  localparam logic [op_w-1:0] op_andn  = 4'd3;

  // lane permutes
  localparam logic [op_w-1:0] op_swap  = 4'd4;
  localparam logic [op_w-1:0] op_dup   = 4'd5;
  localparam logic [op_w-1:0] op_copya = 4'd6;

  // packed single compares, lt and le are ordered
  localparam logic [op_w-1:0] op_cmpeq = 4'd8;
  localparam logic [op_w-1:0] op_cmplt = 4'd9;
  localparam logic [op_w-1:0] op_cmple = 4'd10;

  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [lane_w-10:0] frac;
  } flane_t;

  // same bits, raw for logic and permutes, lanes for compares
  typedef union packed {
    logic [data_w-1:0]       raw;
    flane_t [num_lanes-1:0]  lane;
  } simd_word_u;

endpackage
